/* sim.f */
+incdir+logic
logic/axi_pkg.sv
logic/soc_mem_pkg.sv
logic/axi_rd_if.sv
logic/axi_wr_if.sv
logic/burst_addr_gen.sv
logic/arbiter.sv
logic/axi_mem.sv
logic/mem_subsys_top.sv
sim/tb_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mem_subsys -f sim.f

out=$(./obj_dir/Vtb_mem_subsys)
echo "$out"

# exit status of the search decides pass or fail
echo "$out" | grep -q "^Simulation passed$"

/* sim/tb_mem_subsys.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_mem_subsys;
    import axi_pkg::*;
    import soc_mem_pkg::*;

    localparam int TIMEOUT = 200; // cycles per wait

    typedef enum {AW_READY, W_READY, B_VALID, I_AR_READY, D_AR_READY} sig_t;

    logic                 clk;
    logic                 i_reset;
    logic [`ADDR_W-1:0]   i_i_araddr;
    burst_t               i_i_arburst;
    len_t                 i_i_arlen;
    logic                 i_i_arvalid;
    logic                 i_i_rready;
    logic                 o_i_arready;
    logic [`DATA_W-1:0]   o_i_rdata;
    logic                 o_i_rlast;
    logic                 o_i_rvalid;
    logic [`ADDR_W-1:0]   i_d_araddr;
    len_t                 i_d_arlen;
    size_t                i_d_arsize;
    logic                 i_d_arvalid;
    logic                 i_d_rready;
    logic                 o_d_arready;
    logic [`DATA_W-1:0]   o_d_rdata;
    logic                 o_d_rlast;
    logic                 o_d_rvalid;
    logic [`ADDR_W-1:0]   i_d_awaddr;
    len_t                 i_d_awlen;
    size_t                i_d_awsize;
    logic                 i_d_awvalid;
    logic [`DATA_W-1:0]   i_d_wdata;
    logic [`DATA_W/8-1:0] i_d_wstrb;
    logic                 i_d_wlast;
    logic                 i_d_wvalid;
    logic                 i_d_bready;
    logic                 o_d_awready;
    logic                 o_d_wready;
    logic                 o_d_bvalid;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr = 32'h5228_21ee;
    logic        quiet_i = 1'b0; // instruction side must stay silent
    logic        quiet_d = 1'b0;
    logic [31:0] wbuf [16];
    logic [7:0]  shadow [`MEM_WORDS*4];

    mem_subsys_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            v    = {v[30:0], lfsr[31]};
            lfsr = {lfsr[30:0], fb};
        end
        return v;
    endfunction

    function automatic int byte_base(input logic [31:0] addr);
        return int'((addr >> 2) % `MEM_WORDS) * 4;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        int b;
        b = byte_base(addr);
        return {shadow[b+3], shadow[b+2], shadow[b+1], shadow[b]};
    endfunction

    // 4-byte beats only
    function automatic logic [31:0] next_addr(input logic [31:0] addr, input logic [31:0] start,
                                              input int beats, input burst_t burst);
        logic [31:0] win;
        logic [31:0] base;
        if (burst == BURST_INCR)
            return addr + 32'd4;
        win  = 32'(beats * 4);
        base = (start / win) * win;
        return base + ((addr + 32'd4 - base) % win);
    endfunction

    function automatic logic sig_high(input sig_t s);
        case (s)
            AW_READY:   return o_d_awready;
            W_READY:    return o_d_wready;
            B_VALID:    return o_d_bvalid;
            I_AR_READY: return o_i_arready;
            D_AR_READY: return o_d_arready;
            default:    return 1'b0;
        endcase
    endfunction

    // returns on the falling edge where the signal is high
    task automatic wait_for(input sig_t s, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!sig_high(s) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!sig_high(s))
            report({"timed out waiting for ", what});
    endtask

    task automatic set_rready(input src_t side, input logic v);
        if (side == SRC_DATA)
            i_d_rready = v;
        else
            i_i_rready = v;
    endtask

    always @(negedge clk) begin
        if (quiet_i) begin
            check_eq("instr rvalid quiet", 32'd0, 32'(o_i_rvalid));
            check_eq("instr rlast quiet", 32'd0, 32'(o_i_rlast));
            if (o_d_rvalid)
                check_eq("instr rdata quiet", 32'd0, o_i_rdata);
        end
        if (quiet_d) begin
            check_eq("data rvalid quiet", 32'd0, 32'(o_d_rvalid));
            check_eq("data rlast quiet", 32'd0, 32'(o_d_rlast));
            if (o_i_rvalid)
                check_eq("data rdata quiet", 32'd0, o_d_rdata);
        end
    end

    task automatic write_burst(input string name, input logic [31:0] addr, input int beats,
                               input logic [3:0] strb);
        logic [31:0] a;
        int          b;
        i_d_awaddr  = addr;
        i_d_awlen   = len_t'(beats - 1);
        i_d_awsize  = 3'd2;
        i_d_awvalid = 1'b1;
        wait_for(AW_READY, "awready");
        @(posedge clk);
        #1;
        i_d_awvalid = 1'b0;
        a = addr;
        for (int k = 0; k < beats; k++) begin
            i_d_wdata  = wbuf[k];
            i_d_wstrb  = strb;
            i_d_wlast  = (k == beats - 1);
            i_d_wvalid = 1'b1;
            wait_for(W_READY, "wready");
            b = byte_base(a);
            for (int j = 0; j < 4; j++) begin
                if (strb[j])
                    shadow[b+j] = wbuf[k][8*j +: 8];
            end
            a = next_addr(a, addr, beats, BURST_WRAP);
            @(posedge clk);
            #1;
        end
        i_d_wvalid = 1'b0;
        i_d_wlast  = 1'b0;
        i_d_bready = 1'b1;
        wait_for(B_VALID, "bvalid");
        @(posedge clk);
        #1;
        i_d_bready = 1'b0;
        @(negedge clk);
        check_eq({name, " single bvalid"}, 32'd0, 32'(o_d_bvalid));
        @(posedge clk);
        #1;
    endtask

    task automatic drive_ar(input src_t side, input logic [31:0] addr, input int beats,
                            input burst_t burst);
        if (side == SRC_DATA) begin
            i_d_araddr  = addr;
            i_d_arlen   = len_t'(beats - 1);
            i_d_arsize  = 3'd2;
            i_d_arvalid = 1'b1;
        end else begin
            i_i_araddr  = addr;
            i_i_arlen   = len_t'(beats - 1);
            i_i_arburst = burst;
            i_i_arvalid = 1'b1;
        end
    endtask

    task automatic wait_ar(input src_t side);
        wait_for((side == SRC_DATA) ? D_AR_READY : I_AR_READY, "arready");
        @(posedge clk);
        #1;
        if (side == SRC_DATA)
            i_d_arvalid = 1'b0;
        else
            i_i_arvalid = 1'b0;
    endtask

    // takes R beats, with random rready gaps when stall_mode is set
    task automatic collect(input string name, input src_t side, input logic [31:0] addr,
                           input int beats, input burst_t burst, input logic stall_mode);
        logic [31:0] a;
        logic [31:0] data;
        logic [31:0] held;
        logic        have_held;
        logic        rready;
        int          k;
        int          n;
        int          stall;
        a = addr;
        k = 0;
        n = 0;
        stall = 0;
        have_held = 1'b0;
        set_rready(side, 1'b1);
        while (k < beats && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            data   = (side == SRC_DATA) ? o_d_rdata : o_i_rdata;
            rready = (side == SRC_DATA) ? i_d_rready : i_i_rready;
            if ((side == SRC_DATA) ? o_d_rvalid : o_i_rvalid) begin
                check_eq({name, " data"}, shadow_word(a), data);
                if (rready) begin
                    check_eq({name, " rlast"}, 32'(k == beats - 1),
                             32'((side == SRC_DATA) ? o_d_rlast : o_i_rlast));
                    if (have_held)
                        check_eq({name, " held beat"}, held, data);
                    have_held = 1'b0;
                    k++;
                    a = next_addr(a, addr, beats, burst);
                end else begin
                    held      = data;
                    have_held = 1'b1;
                end
            end else if (have_held) begin
                report({name, ": rvalid dropped while a beat was held"});
                have_held = 1'b0;
            end
            @(posedge clk);
            #1;
            if (stall_mode && stall == 0 && rand_bits(1) == 32'd1)
                stall = int'(rand_bits(2)) + 1;
            set_rready(side, stall == 0);
            if (stall > 0)
                stall--;
        end
        set_rready(side, 1'b0);
        if (k < beats)
            report({name, ": timed out waiting for read data"});
    endtask

    task automatic expect_idle(input string name, input src_t side);
        @(negedge clk);
        check_eq({name, " no extra beat"}, 32'd0,
                 32'((side == SRC_DATA) ? o_d_rvalid : o_i_rvalid));
        @(posedge clk);
        #1;
    endtask

    task automatic read_burst(input string name, input src_t side, input logic [31:0] addr,
                              input int beats, input burst_t burst, input logic stall_mode);
        drive_ar(side, addr, beats, burst);
        wait_ar(side);
        quiet_i = (side == SRC_DATA);
        quiet_d = (side == SRC_INSTR);
        collect(name, side, addr, beats, burst, stall_mode);
        expect_idle(name, side);
        quiet_i = 1'b0;
        quiet_d = 1'b0;
    endtask

    task automatic test_reset;
        @(negedge clk);
        check_eq("reset i_rvalid", 32'd0, 32'(o_i_rvalid));
        check_eq("reset d_rvalid", 32'd0, 32'(o_d_rvalid));
        check_eq("reset d_bvalid", 32'd0, 32'(o_d_bvalid));
        check_eq("reset d_wready", 32'd0, 32'(o_d_wready));
        check_eq("reset i_arready", 32'd1, 32'(o_i_arready));
        check_eq("reset d_awready", 32'd1, 32'(o_d_awready));
        @(posedge clk);
        #1;
    endtask

    task automatic test_write_read;
        for (int k = 0; k < 4; k++)
            wbuf[k] = rand_bits(32);
        quiet_i = 1'b1;
        write_burst("wr_rd", 32'h108, 4, 4'hf); // mid-window start
        read_burst("wr_rd", SRC_DATA, 32'h108, 4, BURST_WRAP, 1'b0);
    endtask

    task automatic test_strobes;
        wbuf[0] = 32'h1122_3344;
        write_burst("strb full", 32'h200, 1, 4'hf);
        wbuf[0] = rand_bits(32);
        write_burst("strb part", 32'h200, 1, 4'b0101);
        read_burst("strb", SRC_DATA, 32'h200, 1, BURST_WRAP, 1'b0);
    endtask

    task automatic test_instr_bursts;
        for (int g = 0; g < 4; g++) begin
            for (int k = 0; k < 4; k++)
                wbuf[k] = rand_bits(32);
            write_burst("preload", 32'h300 + 32'(g * 16), 4, 4'hf);
        end
        read_burst("instr incr", SRC_INSTR, 32'h314, 8, BURST_INCR, 1'b0);
        read_burst("instr wrap", SRC_INSTR, 32'h314, 8, BURST_WRAP, 1'b0);
    endtask

    task automatic test_priority;
        drive_ar(SRC_INSTR, 32'h320, 4, BURST_INCR);
        drive_ar(SRC_DATA, 32'h108, 4, BURST_WRAP);
        @(negedge clk);
        check_eq("prio i_arready", 32'd1, 32'(o_i_arready));
        check_eq("prio d_arready", 32'd0, 32'(o_d_arready));
        @(posedge clk);
        #1;
        i_i_arvalid = 1'b0;
        collect("prio instr", SRC_INSTR, 32'h320, 4, BURST_INCR, 1'b0);
        wait_ar(SRC_DATA); // data request was pending the whole time
        collect("prio data", SRC_DATA, 32'h108, 4, BURST_WRAP, 1'b0);
        expect_idle("prio data", SRC_DATA);
    endtask

    task automatic test_backpressure;
        read_burst("backpressure", SRC_DATA, 32'h324, 8, BURST_WRAP, 1'b1);
    endtask

    initial begin
        i_reset     = 1'b1;
        i_i_araddr  = '0;
        i_i_arburst = BURST_INCR;
        i_i_arlen   = '0;
        i_i_arvalid = 1'b0;
        i_i_rready  = 1'b0;
        i_d_araddr  = '0;
        i_d_arlen   = '0;
        i_d_arsize  = 3'd2;
        i_d_arvalid = 1'b0;
        i_d_rready  = 1'b0;
        i_d_awaddr  = '0;
        i_d_awlen   = '0;
        i_d_awsize  = 3'd2;
        i_d_awvalid = 1'b0;
        i_d_wdata   = '0;
        i_d_wstrb   = '0;
        i_d_wlast   = 1'b0;
        i_d_wvalid  = 1'b0;
        i_d_bready  = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        i_reset = 1'b0;

        test_reset;
        test_write_read;
        test_strobes;
        test_instr_bursts;
        test_priority;
        test_backpressure;

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* logic/mem_subsys_top.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_subsys_top (
    input  logic                 clk,
    input  logic                 i_reset,

    input  logic [`ADDR_W-1:0]   i_i_araddr,
    input  axi_pkg::burst_t      i_i_arburst,
    input  axi_pkg::len_t        i_i_arlen,
    input  logic                 i_i_arvalid,
    input  logic                 i_i_rready,
    output logic                 o_i_arready,
    output logic [`DATA_W-1:0]   o_i_rdata,
    output logic                 o_i_rlast,
    output logic                 o_i_rvalid,

    input  logic [`ADDR_W-1:0]   i_d_araddr,
    input  axi_pkg::len_t        i_d_arlen,
    input  axi_pkg::size_t       i_d_arsize,
    input  logic                 i_d_arvalid,
    input  logic                 i_d_rready,
    output logic                 o_d_arready,
    output logic [`DATA_W-1:0]   o_d_rdata,
    output logic                 o_d_rlast,
    output logic                 o_d_rvalid,

    input  logic [`ADDR_W-1:0]   i_d_awaddr,
    input  axi_pkg::len_t        i_d_awlen,
    input  axi_pkg::size_t       i_d_awsize,
    input  logic                 i_d_awvalid,
    input  logic [`DATA_W-1:0]   i_d_wdata,
    input  logic [`DATA_W/8-1:0] i_d_wstrb,
    input  logic                 i_d_wlast,
    input  logic                 i_d_wvalid,
    input  logic                 i_d_bready,
    output logic                 o_d_awready,
    output logic                 o_d_wready,
    output logic                 o_d_bvalid
);

    axi_rd_if rd_bus (.clk(clk));
    axi_wr_if wr_bus (.clk(clk));

    arbiter u_arbiter (
        .clk         (clk),
        .i_i_araddr  (i_i_araddr),
        .i_i_arburst (i_i_arburst),
        .i_i_arlen   (i_i_arlen),
        .i_i_arvalid (i_i_arvalid),
        .i_i_rready  (i_i_rready),
        .o_i_arready (o_i_arready),
        .o_i_rdata   (o_i_rdata),
        .o_i_rlast   (o_i_rlast),
        .o_i_rvalid  (o_i_rvalid),
        .i_d_araddr  (i_d_araddr),
        .i_d_arlen   (i_d_arlen),
        .i_d_arsize  (i_d_arsize),
        .i_d_arvalid (i_d_arvalid),
        .i_d_rready  (i_d_rready),
        .o_d_arready (o_d_arready),
        .o_d_rdata   (o_d_rdata),
        .o_d_rlast   (o_d_rlast),
        .o_d_rvalid  (o_d_rvalid),
        .i_d_awaddr  (i_d_awaddr),
        .i_d_awlen   (i_d_awlen),
        .i_d_awsize  (i_d_awsize),
        .i_d_awvalid (i_d_awvalid),
        .i_d_wdata   (i_d_wdata),
        .i_d_wstrb   (i_d_wstrb),
        .i_d_wlast   (i_d_wlast),
        .i_d_wvalid  (i_d_wvalid),
        .i_d_bready  (i_d_bready),
        .o_d_awready (o_d_awready),
        .o_d_wready  (o_d_wready),
        .o_d_bvalid  (o_d_bvalid),
        .m_rd        (rd_bus.master),
        .m_wr        (wr_bus.master)
    );

    axi_mem u_mem (
        .clk     (clk),
        .i_reset (i_reset),
        .s_rd    (rd_bus.slave),
        .s_wr    (wr_bus.slave)
    );

endmodule

/* logic/axi_mem.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module axi_mem (
    input  logic     clk,
    input  logic     i_reset,
    axi_rd_if.slave  s_rd,
    axi_wr_if.slave  s_wr
);
    import axi_pkg::*;

    localparam int WORD_LSB = $clog2(`DATA_W / 8);
    localparam int IDX_W    = $clog2(`MEM_WORDS);
    localparam int STRB_W   = `DATA_W / 8;

    logic [`DATA_W-1:0] mem [`MEM_WORDS];

    function automatic logic [IDX_W-1:0] word_idx(input logic [`ADDR_W-1:0] addr);
        return addr[WORD_LSB +: IDX_W]; // wraps modulo depth
    endfunction

    // read engine
    logic               rd_valid;
    len_t               rd_cnt;
    logic [`ID_W-1:0]   rd_id;
    logic [`ADDR_W-1:0] rd_addr;
    logic [`ADDR_W-1:0] rd_start;
    logic [`ADDR_W-1:0] rd_next;
    len_t               rd_len;
    size_t              rd_size;
    burst_t             rd_burst;
    logic [`DATA_W-1:0] rd_data;
    logic               rd_last;
    logic               ar_fire;
    logic               r_fire;

    assign ar_fire = s_rd.arvalid && s_rd.arready;
    assign r_fire  = s_rd.rvalid && s_rd.rready;

    burst_addr_gen u_rd_addr (
        .i_addr       (rd_addr),
        .i_start_addr (rd_start),
        .i_len        (rd_len),
        .i_size       (rd_size),
        .i_burst      (rd_burst),
        .o_next_addr  (rd_next)
    );

    always_ff @(posedge clk) begin
        if (i_reset) begin
            rd_valid <= 1'b0;
            rd_cnt   <= '0;
        end else if (ar_fire) begin
            rd_valid <= 1'b1;
            rd_cnt   <= s_rd.arlen;
        end else if (r_fire) begin
            if (rd_cnt == '0)
                rd_valid <= 1'b0; // last beat taken
            else
                rd_cnt <= rd_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_id    <= s_rd.arid;
            rd_addr  <= s_rd.araddr;
            rd_start <= s_rd.araddr;
            rd_len   <= s_rd.arlen;
            rd_size  <= s_rd.arsize;
            rd_burst <= s_rd.arburst;
            rd_data  <= mem[word_idx(s_rd.araddr)];
            rd_last  <= (s_rd.arlen == '0);
        end else if (r_fire && rd_cnt != '0) begin
            rd_addr  <= rd_next;
            rd_data  <= mem[word_idx(rd_next)];
            rd_last  <= (rd_cnt == len_t'(1));
        end
    end

    assign s_rd.arready = !rd_valid;
    assign s_rd.rvalid  = rd_valid;
    assign s_rd.rid     = rd_id;
    assign s_rd.rdata   = rd_data;
    assign s_rd.rlast   = rd_last;
    assign s_rd.rresp   = RESP_OKAY;

    // write engine
    logic               wr_active;
    logic               b_valid;
    logic [`ADDR_W-1:0] wr_addr;
    logic [`ADDR_W-1:0] wr_start;
    logic [`ADDR_W-1:0] wr_next;
    len_t               wr_len;
    size_t              wr_size;
    burst_t             wr_burst;
    logic               aw_fire;
    logic               w_fire;

    assign aw_fire = s_wr.awvalid && s_wr.awready;
    assign w_fire  = s_wr.wvalid && s_wr.wready;

    burst_addr_gen u_wr_addr (
        .i_addr       (wr_addr),
        .i_start_addr (wr_start),
        .i_len        (wr_len),
        .i_size       (wr_size),
        .i_burst      (wr_burst),
        .o_next_addr  (wr_next)
    );

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_active <= 1'b0;
            b_valid   <= 1'b0;
        end else begin
            if (aw_fire)
                wr_active <= 1'b1;
            else if (w_fire && s_wr.wlast)
                wr_active <= 1'b0;
            if (w_fire && s_wr.wlast)
                b_valid <= 1'b1;
            else if (b_valid && s_wr.bready)
                b_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_addr  <= s_wr.awaddr;
            wr_start <= s_wr.awaddr;
            wr_len   <= s_wr.awlen;
            wr_size  <= s_wr.awsize;
            wr_burst <= s_wr.awburst;
        end else if (w_fire) begin
            wr_addr  <= wr_next;
        end
    end

    // byte lanes written under strobe
    always_ff @(posedge clk) begin
        if (w_fire) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (s_wr.wstrb[b])
                    mem[word_idx(wr_addr)][8*b +: 8] <= s_wr.wdata[8*b +: 8];
            end
        end
    end

    assign s_wr.awready = !wr_active && !b_valid; // idle only once B is taken
    assign s_wr.wready  = wr_active;
    assign s_wr.bvalid  = b_valid;
    assign s_wr.bresp   = RESP_OKAY;

endmodule

/* logic/arbiter.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module arbiter (
    input  logic                 clk,

    // instruction read port
    input  logic [`ADDR_W-1:0]   i_i_araddr,
    input  axi_pkg::burst_t      i_i_arburst,
    input  axi_pkg::len_t        i_i_arlen,
    input  logic                 i_i_arvalid,
    input  logic                 i_i_rready,
    output logic                 o_i_arready,
    output logic [`DATA_W-1:0]   o_i_rdata,
    output logic                 o_i_rlast,
    output logic                 o_i_rvalid,

    // data read port
    input  logic [`ADDR_W-1:0]   i_d_araddr,
    input  axi_pkg::len_t        i_d_arlen,
    input  axi_pkg::size_t       i_d_arsize,
    input  logic                 i_d_arvalid,
    input  logic                 i_d_rready,
    output logic                 o_d_arready,
    output logic [`DATA_W-1:0]   o_d_rdata,
    output logic                 o_d_rlast,
    output logic                 o_d_rvalid,

    // data write port
    input  logic [`ADDR_W-1:0]   i_d_awaddr,
    input  axi_pkg::len_t        i_d_awlen,
    input  axi_pkg::size_t       i_d_awsize,
    input  logic                 i_d_awvalid,
    input  logic [`DATA_W-1:0]   i_d_wdata,
    input  logic [`DATA_W/8-1:0] i_d_wstrb,
    input  logic                 i_d_wlast,
    input  logic                 i_d_wvalid,
    input  logic                 i_d_bready,
    output logic                 o_d_awready,
    output logic                 o_d_wready,
    output logic                 o_d_bvalid,

    axi_rd_if.master             m_rd,
    axi_wr_if.master             m_wr
);
    import axi_pkg::*;
    import soc_mem_pkg::*;

    src_t ar_sel;
    src_t r_sel;

    // instruction side wins when both ask
    assign ar_sel = (!i_i_arvalid && i_d_arvalid) ? SRC_DATA : SRC_INSTR;
    assign r_sel  = src_t'(m_rd.rid[0]);

    assign m_rd.arid    = {{(`ID_W-1){1'b0}}, ar_sel};
    assign m_rd.araddr  = (ar_sel == SRC_DATA) ? i_d_araddr : i_i_araddr;
    assign m_rd.arlen   = (ar_sel == SRC_DATA) ? i_d_arlen : i_i_arlen;
    assign m_rd.arsize  = (ar_sel == SRC_DATA) ? i_d_arsize : INSTR_SIZE;
    assign m_rd.arburst = (ar_sel == SRC_DATA) ? BURST_WRAP : i_i_arburst;
    assign m_rd.arvalid = (ar_sel == SRC_DATA) ? i_d_arvalid : i_i_arvalid;

    assign o_i_arready  = m_rd.arready && (ar_sel == SRC_INSTR);
    assign o_d_arready  = m_rd.arready && (ar_sel == SRC_DATA);

    // read data goes back to whoever the id names
    assign o_i_rdata    = (r_sel == SRC_INSTR) ? m_rd.rdata : '0;
    assign o_i_rlast    = (r_sel == SRC_INSTR) && m_rd.rlast;
    assign o_i_rvalid   = (r_sel == SRC_INSTR) && m_rd.rvalid;
    assign o_d_rdata    = (r_sel == SRC_DATA) ? m_rd.rdata : '0;
    assign o_d_rlast    = (r_sel == SRC_DATA) && m_rd.rlast;
    assign o_d_rvalid   = (r_sel == SRC_DATA) && m_rd.rvalid;
    assign m_rd.rready  = (r_sel == SRC_DATA) ? i_d_rready : i_i_rready;

    // writes only come from the data side
    assign m_wr.awid    = '0;
    assign m_wr.awaddr  = i_d_awaddr;
    assign m_wr.awlen   = i_d_awlen;
    assign m_wr.awsize  = i_d_awsize;
    assign m_wr.awburst = BURST_WRAP;
    assign m_wr.awvalid = i_d_awvalid;
    assign m_wr.wdata   = i_d_wdata;
    assign m_wr.wstrb   = i_d_wstrb;
    assign m_wr.wlast   = i_d_wlast;
    assign m_wr.wvalid  = i_d_wvalid;
    assign m_wr.bready  = i_d_bready;
    assign o_d_awready  = m_wr.awready;
    assign o_d_wready   = m_wr.wready;
    assign o_d_bvalid   = m_wr.bvalid;

endmodule

/* logic/burst_addr_gen.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module burst_addr_gen (
    input  logic [`ADDR_W-1:0] i_addr,
    input  logic [`ADDR_W-1:0] i_start_addr,
    input  axi_pkg::len_t      i_len,
    input  axi_pkg::size_t     i_size,
    input  axi_pkg::burst_t    i_burst,
    output logic [`ADDR_W-1:0] o_next_addr
);
    import axi_pkg::*;

    logic [`ADDR_W-1:0] step;
    logic [`ADDR_W-1:0] incr_addr;
    logic [`ADDR_W-1:0] wrap_mask;

    assign step      = `ADDR_W'(1) << i_size;
    assign incr_addr = i_addr + step;
    // window is (len+1) beats, len+1 is a power of two for WRAP
    assign wrap_mask = ((`ADDR_W'(i_len) + `ADDR_W'(1)) << i_size) - `ADDR_W'(1);

    always_comb begin
        case (i_burst)
            BURST_FIXED: o_next_addr = i_addr;
            BURST_INCR:  o_next_addr = incr_addr;
            BURST_WRAP:  o_next_addr = (i_start_addr & ~wrap_mask) | (incr_addr & wrap_mask);
            default:     o_next_addr = i_addr; // reserved encoding
        endcase
    end

endmodule

/* logic/axi_wr_if.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

interface axi_wr_if (
    input logic clk
);
    import axi_pkg::*;

    logic [`ID_W-1:0]     awid;
    logic [`ADDR_W-1:0]   awaddr;
    len_t                 awlen;
    size_t                awsize;
    burst_t               awburst;
    logic                 awvalid;
    logic                 awready;

    logic [`DATA_W-1:0]   wdata;
    logic [`DATA_W/8-1:0] wstrb;
    logic                 wlast;
    logic                 wvalid;
    logic                 wready;

    resp_t                bresp;
    logic                 bvalid;
    logic                 bready;

    modport master (
        input  clk,
        output awid, awaddr, awlen, awsize, awburst, awvalid,
        output wdata, wstrb, wlast, wvalid, bready,
        input  awready, wready, bresp, bvalid
    );

    modport slave (
        input  clk,
        input  awid, awaddr, awlen, awsize, awburst, awvalid,
        input  wdata, wstrb, wlast, wvalid, bready,
        output awready, wready, bresp, bvalid
    );

endinterface

/* logic/axi_rd_if.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

interface axi_rd_if (
    input logic clk
);
    import axi_pkg::*;

    // AR channel
    logic [`ID_W-1:0]   arid;
    logic [`ADDR_W-1:0] araddr;
    len_t               arlen;
    size_t              arsize;
    burst_t             arburst;
    logic               arvalid;
    logic               arready;

    // R channel
    logic [`ID_W-1:0]   rid;
    logic [`DATA_W-1:0] rdata;
    resp_t              rresp;
    logic               rlast;
    logic               rvalid;
    logic               rready;

    modport master (
        input  clk,
        output arid, araddr, arlen, arsize, arburst, arvalid, rready,
        input  arready, rid, rdata, rresp, rlast, rvalid
    );

    modport slave (
        input  clk,
        input  arid, araddr, arlen, arsize, arburst, arvalid, rready,
        output arready, rid, rdata, rresp, rlast, rvalid
    );

endinterface

/* logic/soc_mem_pkg.sv */
package soc_mem_pkg;

    // requester id, lands in bit 0 of arid
    typedef enum logic {
        SRC_INSTR = 1'b0,
        SRC_DATA  = 1'b1
    } src_t;

    // instruction fetch is always word wide
    localparam axi_pkg::size_t INSTR_SIZE = 3'd2;

endpackage

/* logic/axi_pkg.sv */
package axi_pkg;

    // burst type, 2'b11 is reserved
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

    // bytes per beat = 2 ** size
    typedef logic [2:0] size_t;

    // beats in a burst minus one
    typedef logic [7:0] len_t;

endpackage

/* logic/mem_config.svh */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// bus widths
`define ADDR_W    32
`define DATA_W    32
`define ID_W      4

// depth of the slave array in words, power of two
`define MEM_WORDS 1024

`endif
